//--- vid_pkg.sv
/*
 * Shared definitions for the arcade video pipeline
 *   Frame geometry and blanking/sync positions
 *   Tile RAM, font PROM and palette PROM sizes
 *   Pipeline depth and PROM programming selector
 *   Beam, sync, text pixel, tile and colour structs
 */
`default_nettype none

package vid_pkg;

    // Horizontal geometry in pixels
    localparam int H_TOTAL  = 64;
    localparam int H_VIS    = 48;
    localparam int HS_START = 52;
    localparam int HS_END   = 56;   // Exclusive

    // Vertical geometry in lines
    localparam int V_TOTAL  = 40;
    localparam int V_VIS    = 32;
    localparam int VS_START = 34;
    localparam int VS_END   = 36;   // Exclusive

    localparam int TILE_COLS = 8;
    localparam int TILE_ROWS = 4;
    localparam int TILE_AW   = 5;
    localparam int FONT_AW   = 7;   // Code plus glyph row
    localparam int PAL_AW    = 4;

    // CPU address of the background colour register
    localparam int BG_ADDR = 32;

    // Beam position to colour output
    localparam int PIPE_DEPTH = 4;

    localparam logic PROG_FONT = 1'b0;
    localparam logic PROG_PAL  = 1'b1;

    typedef struct packed {
        logic [5:0] h;
        logic [5:0] v;
    } beam_t;

    // All flags active high
    typedef struct packed {
        logic hb;
        logic vb;
        logic hs;
        logic vs;
    } sync_t;

    typedef struct packed {
        logic [3:0] colour;
        logic       opaque;
    } txt_pix_t;

    typedef struct packed {
        logic [2:0] red;
        logic [2:0] green;
        logic [1:0] blue;
    } rgb_t;

    typedef struct packed {
        logic [3:0] code;
        logic [3:0] colour;
    } tile_t;

endpackage

`default_nettype wire

//--- vid_delay.sv
/*
 * Fixed-depth delay line for any packed payload
 *   Shift chain advanced on the pixel enable
 */
`timescale 1ns/1ps
`default_nettype none

module vid_delay #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
)(
    input  wire     clk,
    input  wire     rst_n,
    input  wire     pxl_cen,

    input  wire T   din,
    output T        dout
);

T chain [DEPTH];

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        chain <= '{default: '0};
    end else if (pxl_cen) begin
        chain[0] <= din;
        for (int i = 1; i < DEPTH; i++) begin
            chain[i] <= chain[i-1];
        end
    end
end

assign dout = chain[DEPTH-1];   // Oldest entry

endmodule

`default_nettype wire

//--- vid_timing.sv
/*
 * Beam timing generator
 *   Free-running horizontal and vertical counters
 *   Registered blanking and sync flags aligned with the counters
 */
`timescale 1ns/1ps
`default_nettype none

module vid_timing(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             pxl_cen,    // Pixel step enable

    output vid_pkg::beam_t  beam,
    output vid_pkg::sync_t  syn_raw
);

logic [5:0] h_nx;
logic [5:0] v_nx;
logic       h_last;
logic       v_last;

assign h_last = beam.h == 6'(vid_pkg::H_TOTAL - 1);
assign v_last = beam.v == 6'(vid_pkg::V_TOTAL - 1);

// Next beam position, the flags below are decoded from it
always_comb begin
    h_nx = beam.h + 6'd1;
    v_nx = beam.v;
    if (h_last) begin
        h_nx = 6'd0;
        v_nx = v_last ? 6'd0 : beam.v + 6'd1;
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        beam    <= '0;
        syn_raw <= '0;
    end else if (pxl_cen) begin
        beam.h     <= h_nx;
        beam.v     <= v_nx;
        syn_raw.hb <= h_nx >= 6'(vid_pkg::H_VIS);
        syn_raw.vb <= v_nx >= 6'(vid_pkg::V_VIS);
        syn_raw.hs <= h_nx >= 6'(vid_pkg::HS_START) &&
                      h_nx <  6'(vid_pkg::HS_END);
        syn_raw.vs <= v_nx >= 6'(vid_pkg::VS_START) &&
                      v_nx <  6'(vid_pkg::VS_END);
    end
end

endmodule

`default_nettype wire

//--- vid_txt.sv
/*
 * Text layer
 *   Tile RAM written by the CPU
 *   Font PROM loaded through the programming port
 *   Three-step fetch and serialisation of the glyph row
 */
`timescale 1ns/1ps
`default_nettype none

module vid_txt(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 pxl_cen,

    input  wire vid_pkg::beam_t beam,
    // CPU interface
    input  wire                 cpu_we,
    input  wire     [ 5:0]      cpu_addr,
    input  wire     [ 7:0]      cpu_data,
    // PROM programming
    input  wire                 prog_we,
    input  wire                 prog_sel,
    input  wire     [ 6:0]      prog_addr,
    input  wire     [ 7:0]      prog_data,

    output vid_pkg::txt_pix_t   txt
);

localparam int TILE_N = vid_pkg::TILE_COLS * vid_pkg::TILE_ROWS;

vid_pkg::tile_t tile_ram [TILE_N];
logic [7:0]     font_rom [2**vid_pkg::FONT_AW];

logic [vid_pkg::TILE_AW-1:0] tile_addr;
logic [vid_pkg::FONT_AW-1:0] font_addr;

vid_pkg::tile_t tile_q;     // Step 1
logic [2:0]     row_q;
logic [7:0]     font_q;     // Step 2
logic [3:0]     col_q;
logic [2:0]     pix_off;    // Pixel within the cell, aligned with font_q

// Row v/8 and column h/8, rows past the screen wrap
assign tile_addr = {beam.v[4:3], beam.h[5:3]};
assign font_addr = {tile_q.code, row_q};

always_ff @(posedge clk) begin
    if (cpu_we && cpu_addr < 6'(TILE_N)) begin
        tile_ram[cpu_addr[vid_pkg::TILE_AW-1:0]] <= cpu_data;
    end
end

always_ff @(posedge clk) begin
    if (prog_we && prog_sel == vid_pkg::PROG_FONT) begin
        font_rom[prog_addr] <= prog_data;
    end
end

// Tile fetch
always_ff @(posedge clk) begin
    if (pxl_cen) begin
        tile_q <= tile_ram[tile_addr];
        row_q  <= beam.v[2:0];
    end
end

// Glyph row fetch, colour follows along
always_ff @(posedge clk) begin
    if (pxl_cen) begin
        font_q <= font_rom[font_addr];
        col_q  <= tile_q.colour;
    end
end

vid_delay #(
    .T          ( logic [2:0]   ),
    .DEPTH      ( 2             )
) u_off_dly(
    .clk        ( clk           ),
    .rst_n      ( rst_n         ),
    .pxl_cen    ( pxl_cen       ),
    .din        ( beam.h[2:0]   ),
    .dout       ( pix_off       )
);

// Leftmost pixel is the MSB of the glyph row
always_ff @(posedge clk) begin
    if (pxl_cen) begin
        txt.opaque <= font_q[3'd7 - pix_off];
        txt.colour <= col_q;
    end
end

endmodule

`default_nettype wire

//--- vid_colmix.sv
/*
 * Colour mixer
 *   Background colour register written by the CPU
 *   Text over background priority
 *   Palette PROM lookup with blanking to black
 */
`timescale 1ns/1ps
`default_nettype none

module vid_colmix(
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     pxl_cen,

    input  wire vid_pkg::txt_pix_t  txt,
    input  wire vid_pkg::sync_t     syn_dly,
    // CPU interface
    input  wire                     cpu_we,
    input  wire     [ 5:0]          cpu_addr,
    input  wire     [ 7:0]          cpu_data,
    // PROM programming
    input  wire                     prog_we,
    input  wire                     prog_sel,
    input  wire     [ 6:0]          prog_addr,
    input  wire     [ 7:0]          prog_data,

    output vid_pkg::rgb_t           rgb,
    output vid_pkg::sync_t          syn
);

localparam logic [1:0] FILL_DONE = 2'(vid_pkg::PIPE_DEPTH - 1);

vid_pkg::rgb_t pal_rom [2**vid_pkg::PAL_AW];

logic [vid_pkg::PAL_AW-1:0] bg_col;
logic [vid_pkg::PAL_AW-1:0] pal_idx;
logic [1:0]                 fill;   // Pixel steps since reset, saturating
logic                       blank;

always_ff @(posedge clk) begin
    if (prog_we && prog_sel == vid_pkg::PROG_PAL) begin
        pal_rom[prog_addr[vid_pkg::PAL_AW-1:0]] <= prog_data;
    end
end

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        bg_col <= '0;
    end else if (cpu_we && cpu_addr == 6'(vid_pkg::BG_ADDR)) begin
        bg_col <= cpu_data[vid_pkg::PAL_AW-1:0];
    end
end

assign pal_idx = txt.opaque ? txt.colour : bg_col;

// Black while the earlier stages still hold reset-time data
assign blank = syn_dly.hb | syn_dly.vb | (fill != FILL_DONE);

always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
        fill <= '0;
        rgb  <= '0;
        syn  <= '0;
    end else if (pxl_cen) begin
        if (fill != FILL_DONE) begin
            fill <= fill + 2'd1;
        end
        rgb <= blank ? '0 : pal_rom[pal_idx];
        syn <= syn_dly;     // Leaves together with rgb
    end
end

endmodule

`default_nettype wire

//--- vid_video.sv
/*
 * Video subsystem top level
 *   Beam timing, text layer, sync delay line and colour mixer
 */
`timescale 1ns/1ps
`default_nettype none

module vid_video(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             pxl_cen,
    // CPU interface
    input  wire             cpu_we,
    input  wire  [ 5:0]     cpu_addr,
    input  wire  [ 7:0]     cpu_data,
    // PROM programming
    input  wire             prog_we,
    input  wire             prog_sel,
    input  wire  [ 6:0]     prog_addr,
    input  wire  [ 7:0]     prog_data,
    // Video out
    output vid_pkg::rgb_t   rgb,
    output vid_pkg::sync_t  syn
);

vid_pkg::beam_t     beam;
vid_pkg::sync_t     syn_raw;
vid_pkg::sync_t     syn_dly;
vid_pkg::txt_pix_t  txt;

vid_timing u_timing(
    .clk        ( clk           ),
    .rst_n      ( rst_n         ),
    .pxl_cen    ( pxl_cen       ),
    .beam       ( beam          ),
    .syn_raw    ( syn_raw       )
);

vid_txt u_txt(
    .clk        ( clk           ),
    .rst_n      ( rst_n         ),
    .pxl_cen    ( pxl_cen       ),
    .beam       ( beam          ),
    .cpu_we     ( cpu_we        ),
    .cpu_addr   ( cpu_addr      ),
    .cpu_data   ( cpu_data      ),
    .prog_we    ( prog_we       ),
    .prog_sel   ( prog_sel      ),
    .prog_addr  ( prog_addr     ),
    .prog_data  ( prog_data     ),
    .txt        ( txt           )
);

// Matches the three text fetch steps
vid_delay #(
    .T          ( vid_pkg::sync_t           ),
    .DEPTH      ( vid_pkg::PIPE_DEPTH - 1   )
) u_syn_dly(
    .clk        ( clk           ),
    .rst_n      ( rst_n         ),
    .pxl_cen    ( pxl_cen       ),
    .din        ( syn_raw       ),
    .dout       ( syn_dly       )
);

vid_colmix u_colmix(
    .clk        ( clk           ),
    .rst_n      ( rst_n         ),
    .pxl_cen    ( pxl_cen       ),
    .txt        ( txt           ),
    .syn_dly    ( syn_dly       ),
    .cpu_we     ( cpu_we        ),
    .cpu_addr   ( cpu_addr      ),
    .cpu_data   ( cpu_data      ),
    .prog_we    ( prog_we       ),
    .prog_sel   ( prog_sel      ),
    .prog_addr  ( prog_addr     ),
    .prog_data  ( prog_data     ),
    .rgb        ( rgb           ),
    .syn        ( syn           )
);

endmodule

`default_nettype wire

//--- vid_properties.sv
/*
 * Concurrent checks on the video outputs
 *   Black whenever blanked
 *   Each sync pulse inside its blanking interval
 */
`timescale 1ns/1ps
`default_nettype none

module vid_properties(
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire vid_pkg::rgb_t  rgb,
    input  wire vid_pkg::sync_t syn
);

int fail_cnt = 0;   // Assertion failures so far

rgb_black_in_blank: assert property (
    @(posedge clk) disable iff (!rst_n)
    (syn.hb || syn.vb) |-> rgb == '0
) else begin
    $error("rgb is not black during blanking");
    fail_cnt++;
end

hs_in_hblank: assert property (
    @(posedge clk) disable iff (!rst_n)
    syn.hs |-> syn.hb
) else begin
    $error("hs outside horizontal blanking");
    fail_cnt++;
end

vs_in_vblank: assert property (
    @(posedge clk) disable iff (!rst_n)
    syn.vs |-> syn.vb
) else begin
    $error("vs outside vertical blanking");
    fail_cnt++;
end

endmodule

bind vid_video vid_properties u_props(
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .rgb        ( rgb       ),
    .syn        ( syn       )
);

`default_nettype wire

//--- vid_tb.sv
/*
 * Testbench for the video subsystem
 *   Clock, reset, font/palette/tile loading
 *   Random tile, background and palette updates in vertical blanking
 *   Frame model and typed compare tasks
 */
`timescale 1ns/1ps
`default_nettype none

module vid_tb;

localparam int FRAME_PIX   = vid_pkg::H_TOTAL * vid_pkg::V_TOTAL;
localparam int RUN_TICKS   = vid_pkg::PIPE_DEPTH + 4 * FRAME_PIX;
localparam int RUN_TIMEOUT = 2 * RUN_TICKS + 1000;  // Clock cycles
localparam int N_UPDATES   = 12;                    // Writes per vertical blanking
localparam int TILE_N      = vid_pkg::TILE_COLS * vid_pkg::TILE_ROWS;

logic           clk;
logic           rst_n;
logic           pxl_cen;
logic           cpu_we;
logic [5:0]     cpu_addr;
logic [7:0]     cpu_data;
logic           prog_we;
logic           prog_sel;
logic [6:0]     prog_addr;
logic [7:0]     prog_data;
vid_pkg::rgb_t  rgb;
vid_pkg::sync_t syn;

// Model copies of the memories
logic [7:0]     font_m [2**vid_pkg::FONT_AW];
vid_pkg::rgb_t  pal_m  [2**vid_pkg::PAL_AW];
vid_pkg::tile_t tile_m [TILE_N];
logic [3:0]     bg_m;

integer seed;
int     ticks;      // pxl_cen ticks since the run started
int     cycles;
int     wr_left;    // Pending writes of the current update burst

vid_video DUT(
    .clk        ( clk           ),
    .rst_n      ( rst_n         ),
    .pxl_cen    ( pxl_cen       ),
    .cpu_we     ( cpu_we        ),
    .cpu_addr   ( cpu_addr      ),
    .cpu_data   ( cpu_data      ),
    .prog_we    ( prog_we       ),
    .prog_sel   ( prog_sel      ),
    .prog_addr  ( prog_addr     ),
    .prog_data  ( prog_data     ),
    .rgb        ( rgb           ),
    .syn        ( syn           )
);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

task automatic fail_now();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped at the first error");
endtask

task automatic next_cycle();
    @(posedge clk);
    #1;
endtask

task automatic idle_bus();
    cpu_we  = 1'b0;
    prog_we = 1'b0;
endtask

// CPU write for the coming edge with the model updated at once
task automatic pulse_cpu(input logic [5:0] addr, input logic [7:0] data);
    cpu_we   = 1'b1;
    cpu_addr = addr;
    cpu_data = data;
    if (addr < 6'(TILE_N)) begin
        tile_m[addr[vid_pkg::TILE_AW-1:0]] = data;
    end else if (addr == 6'(vid_pkg::BG_ADDR)) begin
        bg_m = data[3:0];
    end
endtask

task automatic pulse_prog(input logic sel, input logic [6:0] addr, input logic [7:0] data);
    prog_we   = 1'b1;
    prog_sel  = sel;
    prog_addr = addr;
    prog_data = data;
    if (sel == vid_pkg::PROG_FONT) begin
        font_m[addr] = data;
    end else begin
        pal_m[addr[vid_pkg::PAL_AW-1:0]] = data;    // Palette uses the low address bits
    end
endtask

// Runs with pxl_cen low while the beam waits at its reset position
task automatic load_memories();
    for (int i = 0; i < 2**vid_pkg::FONT_AW; i++) begin
        idle_bus();
        pulse_prog(vid_pkg::PROG_FONT, 7'(i), 8'($random(seed)));
        next_cycle();
    end
    for (int i = 0; i < 2**vid_pkg::PAL_AW; i++) begin
        idle_bus();
        pulse_prog(vid_pkg::PROG_PAL, 7'(i), 8'($random(seed)));
        next_cycle();
    end
    for (int i = 0; i < TILE_N; i++) begin
        idle_bus();
        pulse_cpu(6'(i), 8'($random(seed)));
        next_cycle();
    end
    idle_bus();
    pulse_cpu(6'(vid_pkg::BG_ADDR), 8'($random(seed)));
    next_cycle();
    idle_bus();
endtask

task automatic random_update();
    int kind;
    kind = $random(seed) & 3;
    if (kind < 2) begin
        pulse_cpu(6'($random(seed) & 31), 8'($random(seed)));
    end else if (kind == 2) begin
        pulse_cpu(6'(vid_pkg::BG_ADDR), 8'($random(seed)));
    end else begin
        pulse_prog(vid_pkg::PROG_PAL, 7'($random(seed)), 8'($random(seed)));
    end
endtask

function automatic vid_pkg::sync_t model_sync(input int h, input int v);
    vid_pkg::sync_t s;
    s.hb = h >= vid_pkg::H_VIS;
    s.vb = v >= vid_pkg::V_VIS;
    s.hs = h >= vid_pkg::HS_START && h < vid_pkg::HS_END;
    s.vs = v >= vid_pkg::VS_START && v < vid_pkg::VS_END;
    return s;
endfunction

function automatic vid_pkg::rgb_t model_rgb(input int h, input int v);
    vid_pkg::tile_t t;
    logic [7:0]     glyph;
    logic [3:0]     idx;
    if (h >= vid_pkg::H_VIS || v >= vid_pkg::V_VIS) begin
        return '0;      // Blanked
    end
    t     = tile_m[(v / 8) * vid_pkg::TILE_COLS + h / 8];
    glyph = font_m[t.code * 8 + v % 8];
    // Leftmost pixel of the cell is bit 7
    if (glyph[7 - h % 8]) begin
        idx = t.colour;
    end else begin
        idx = bg_m;
    end
    return pal_m[idx];
endfunction

task automatic check_rgb(input vid_pkg::rgb_t got, input vid_pkg::rgb_t exp,
                         input int h, input int v);
    if (got !== exp) begin
        $display("Mismatch rgb at h=%0d v=%0d: got %h, expected %h", h, v, got, exp);
        fail_now();
    end
endtask

task automatic check_sync(input vid_pkg::sync_t got, input vid_pkg::sync_t exp,
                          input int h, input int v);
    if (got !== exp) begin
        $display("Mismatch syn at h=%0d v=%0d: got %h, expected %h", h, v, got, exp);
        fail_now();
    end
endtask

// Output after tick n belongs to beam position n - PIPE_DEPTH
task automatic check_tick(input int n);
    int q;
    int h;
    int v;
    if (DUT.u_props.fail_cnt != 0) begin
        $display("A bound assertion on the video outputs failed");
        fail_now();
    end else if (n < vid_pkg::PIPE_DEPTH) begin
        check_rgb(rgb, '0, -1, -1);     // Pipeline still filling
        check_sync(syn, '0, -1, -1);
    end else begin
        q = n - vid_pkg::PIPE_DEPTH;
        h = q % vid_pkg::H_TOTAL;
        v = (q / vid_pkg::H_TOTAL) % vid_pkg::V_TOTAL;
        check_sync(syn, model_sync(h, v), h, v);
        check_rgb(rgb, model_rgb(h, v), h, v);
        // Whole pipeline is inside vertical blanking here
        if (v == vid_pkg::V_VIS + 1 && h == 0) begin
            wr_left = N_UPDATES;
        end
    end
endtask

initial begin
    seed      = 66150;
    ticks     = 0;
    cycles    = 0;
    wr_left   = 0;
    rst_n     = 1'b0;
    pxl_cen   = 1'b0;
    cpu_we    = 1'b0;
    cpu_addr  = '0;
    cpu_data  = '0;
    prog_we   = 1'b0;
    prog_sel  = vid_pkg::PROG_FONT;
    prog_addr = '0;
    prog_data = '0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    check_rgb(rgb, '0, -1, -1);
    check_sync(syn, '0, -1, -1);
    load_memories();
    while (ticks < RUN_TICKS) begin
        if (cycles >= RUN_TIMEOUT) begin
            $display("Timeout: four frames did not complete within %0d cycles", RUN_TIMEOUT);
            fail_now();
        end else begin
            pxl_cen = ~pxl_cen;     // Every second cycle
            idle_bus();
            if (wr_left > 0) begin
                random_update();
                wr_left--;
            end
            next_cycle();
            cycles++;
            if (pxl_cen) begin
                ticks++;
                check_tick(ticks);
            end
        end
    end
    idle_bus();
    pxl_cen = 1'b0;
    if (DUT.u_props.fail_cnt == 0) begin
        $display("Test OK");
        $finish;
    end else begin
        $display("A bound assertion on the video outputs failed");
        fail_now();
    end
end

endmodule

`default_nettype wire

//--- vid_video.f
vid_pkg.sv
vid_delay.sv
vid_timing.sv
vid_txt.sv
vid_colmix.sv
vid_video.sv
vid_properties.sv
vid_tb.sv

//--- Bender.yml
package:
  name: vid_video

sources:
  - vid_pkg.sv
  - vid_delay.sv
  - vid_timing.sv
  - vid_txt.sv
  - vid_colmix.sv
  - vid_video.sv
  - target: test
    files:
      - vid_properties.sv
      - vid_tb.sv
